/* rtl/game_pkg.sv */
package game_pkg;

	typedef struct packed {
		logic [2:0] tree_speed;
		logic [1:0] bird_speed;
		logic [1:0] bird_count_m1; // birds minus one
		logic [3:0] bird_life;
		logic [1:0] trees_to_add;
	} level_cfg_t;

	// two bcd digits, [1] is tens
	typedef logic [1:0][3:0] bcd2_t;

	localparam int NUM_LEVELS = 4;

	// levels past the last entry keep using it
	localparam level_cfg_t LEVEL_TABLE [NUM_LEVELS] = '{
		'{tree_speed: 3'd1, bird_speed: 2'd1, bird_count_m1: 2'd0, bird_life: 4'd2, trees_to_add: 2'd1},
		'{tree_speed: 3'd2, bird_speed: 2'd1, bird_count_m1: 2'd1, bird_life: 4'd3, trees_to_add: 2'd2},
		'{tree_speed: 3'd3, bird_speed: 2'd2, bird_count_m1: 2'd2, bird_life: 4'd4, trees_to_add: 2'd2},
		'{tree_speed: 3'd4, bird_speed: 2'd3, bird_count_m1: 2'd3, bird_life: 4'd5, trees_to_add: 2'd3}
	};

	localparam int COOLDOWN_FRAMES = 50;
	localparam int RAPID_COOLDOWN_FRAMES = 20;
	localparam int TREE_PERIOD = 400;
	localparam int POWERUP_FRAMES = 1000;
	localparam int RED_FRAMES = 64;
	localparam int LEVEL_PAUSE_FRAMES = 100;
	localparam int START_HEARTS = 3;
	localparam int MAX_HEARTS = 3;

	localparam int PU_SHIELD = 0;
	localparam int PU_RAPID = 1;
	localparam int PU_DAMAGE = 2;
	localparam int PU_LIFE = 3;

endpackage

/* rtl/level_if.sv */
`timescale 1ns/1ps

// level settings from level_fsm, level_up back from game_controller
interface level_if;

	game_pkg::level_cfg_t cfg; // settings of the running level
	logic level_up; // one clk strobe

	modport fsm_side (
		output cfg,
		input level_up
	);

	modport ctrl_side (
		input cfg,
		output level_up
	);

endinterface

/* rtl/level_fsm.sv */
`timescale 1ns/1ps

module level_fsm (
	input logic clk,
	input logic resetN,
	level_if.fsm_side lvl,
	output logic [2:0] tree_speed,
	output logic [1:0] bird_speed,
	output game_pkg::bcd2_t level_num
);

	localparam int IDX_W = $clog2(game_pkg::NUM_LEVELS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(game_pkg::NUM_LEVELS - 1);

	logic [IDX_W-1:0] level_idx; // 0 is level 1
	game_pkg::bcd2_t level_num_next;

	// bcd increment, 99 rolls over to 00
	always_comb begin
		level_num_next = level_num;
		if (level_num[0] == 4'd9) begin
			level_num_next[0] = 4'd0;
			if (level_num[1] == 4'd9)
				level_num_next[1] = 4'd0;
			else
				level_num_next[1] = level_num[1] + 4'd1;
		end else begin
			level_num_next[0] = level_num[0] + 4'd1;
		end
	end

	// not gated by the frame strobe
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			level_idx <= '0;
			level_num <= {4'd0, 4'd1};
		end else if (lvl.level_up) begin
			level_num <= level_num_next;
			if (level_idx != LAST_IDX)
				level_idx <= level_idx + 1'b1; // stays on the last table entry
		end
	end

	assign lvl.cfg = game_pkg::LEVEL_TABLE[level_idx];

	// motion logic outside needs these directly
	assign tree_speed = lvl.cfg.tree_speed;
	assign bird_speed = lvl.cfg.bird_speed;

endmodule

/* rtl/game_controller.sv */
`timescale 1ns/1ps

module game_controller #(
	parameter int MAX_SHOTS = 8,
	parameter int MAX_TREES = 16
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input logic shoot,
	input logic [3:0] bird_alive,
	input logic player_active,
	input logic rapid,
	level_if.ctrl_side lvl,
	output logic [MAX_SHOTS-1:0] deploy_shot,
	output logic [MAX_TREES-1:0] deploy_tree,
	output logic [3:0] deploy_bird,
	output logic deploy_pickup,
	output logic add_time,
	output game_pkg::bcd2_t time_to_add
);

	localparam int SHOT_W = $clog2(MAX_SHOTS);
	localparam int TREE_W = $clog2(MAX_TREES);
	localparam int CD_W = $clog2(game_pkg::COOLDOWN_FRAMES);
	localparam int TP_W = $clog2(game_pkg::TREE_PERIOD);
	localparam int PAUSE_W = $clog2(game_pkg::LEVEL_PAUSE_FRAMES + 1);

	logic [SHOT_W-1:0] shot_idx;
	logic [TREE_W-1:0] tree_idx;
	logic [CD_W-1:0] cooldown;
	logic [TP_W-1:0] tree_cnt;
	logic [7:0] tree_stock; // trees still to be released
	logic [PAUSE_W-1:0] pause_cnt;
	logic start_level; // pending level start after reset
	logic level_done; // level_up already sent for this level
	logic [3:0] last_birds;
	logic level_start;
	logic tree_due;

	assign level_start = start_level || (pause_cnt == PAUSE_W'(1));
	assign tree_due = (tree_cnt == TP_W'(game_pkg::TREE_PERIOD - 1)) && (tree_stock != 8'd0);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			deploy_shot <= '0;
			deploy_tree <= '0;
			deploy_bird <= '0;
			deploy_pickup <= 1'b0;
			add_time <= 1'b1; // loads the starting time
			time_to_add <= {4'd9, 4'd9};
			lvl.level_up <= 1'b0;
			shot_idx <= '0;
			tree_idx <= '0;
			cooldown <= '0;
			tree_cnt <= '0;
			tree_stock <= 8'd0;
			pause_cnt <= '0;
			start_level <= 1'b1;
			level_done <= 1'b1; // armed once birds show up
			last_birds <= 4'd0;
		end else begin
			add_time <= 1'b0;
			time_to_add <= {4'd0, 4'd0};
			lvl.level_up <= 1'b0;
			if (start_of_frame) begin
				deploy_shot <= '0;
				deploy_tree <= '0;
				deploy_bird <= '0;
				deploy_pickup <= 1'b0;
				start_level <= 1'b0;
				last_birds <= bird_alive;
				if (cooldown != '0)
					cooldown <= cooldown - 1'b1;
				if (pause_cnt != '0)
					pause_cnt <= pause_cnt - 1'b1;
				tree_cnt <= (tree_cnt == TP_W'(game_pkg::TREE_PERIOD - 1)) ?
					'0 : tree_cnt + 1'b1;

				if (shoot && (cooldown == '0)) begin
					deploy_shot[shot_idx] <= 1'b1;
					shot_idx <= (shot_idx == SHOT_W'(MAX_SHOTS - 1)) ? '0 : shot_idx + 1'b1;
					cooldown <= rapid ? CD_W'(game_pkg::RAPID_COOLDOWN_FRAMES - 1) :
						CD_W'(game_pkg::COOLDOWN_FRAMES - 1);
				end

				if (tree_due) begin
					deploy_tree[tree_idx] <= 1'b1;
					tree_idx <= (tree_idx == TREE_W'(MAX_TREES - 1)) ? '0 : tree_idx + 1'b1;
				end
				tree_stock <= tree_stock - {7'd0, tree_due} +
					(level_start ? {6'd0, lvl.cfg.trees_to_add} : 8'd0);

				if (level_start) begin
					for (int i = 0; i < 4; i++)
						deploy_bird[i] <= (2'(i) <= lvl.cfg.bird_count_m1);
					deploy_pickup <= 1'b1;
				end

				if (bird_alive != 4'd0) begin
					level_done <= 1'b0;
				end else if (!level_done) begin
					lvl.level_up <= 1'b1; // all birds down
					level_done <= 1'b1;
					pause_cnt <= PAUSE_W'(game_pkg::LEVEL_PAUSE_FRAMES);
				end

				if ((bird_alive < last_birds) && player_active) begin
					add_time <= 1'b1; // bonus per bird kill
					time_to_add <= {4'd1, 4'd0};
				end
			end
		end
	end

endmodule

/* rtl/player_status.sv */
`timescale 1ns/1ps

module player_status (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input logic hit_pulse,
	input logic god_mode,
	input logic pickup_hit,
	input logic out_of_time,
	input logic [7:0] random,
	output logic player_active,
	output logic player_red,
	output logic shield,
	output logic more_damage,
	output logic rapid,
	output logic [1:0] num_of_hearts
);

	localparam int RED_W = $clog2(game_pkg::RED_FRAMES + 1);
	localparam int PU_W = $clog2(game_pkg::POWERUP_FRAMES + 1);

	logic [RED_W-1:0] red_cnt; // hit flash
	logic [PU_W-1:0] pu_cnt;
	logic [3:0] powerups; // shield, rapid, damage, life
	logic invincible;

	assign invincible = (red_cnt != '0) || god_mode || powerups[game_pkg::PU_SHIELD];

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			player_active <= 1'b1;
			num_of_hearts <= 2'(game_pkg::START_HEARTS);
			red_cnt <= '0;
			pu_cnt <= '0;
			powerups <= 4'b0;
		end else if (start_of_frame) begin
			if (red_cnt != '0)
				red_cnt <= red_cnt - 1'b1;
			if (pu_cnt != '0)
				pu_cnt <= pu_cnt - 1'b1;
			else
				powerups <= 4'b0; // timer ran out

			if (hit_pulse && !invincible) begin
				num_of_hearts <= num_of_hearts - 2'd1;
				if (num_of_hearts > 2'd1)
					red_cnt <= RED_W'(game_pkg::RED_FRAMES);
				else
					player_active <= 1'b0; // last heart gone
			end

			if (out_of_time)
				player_active <= 1'b0;

			if (pickup_hit) begin
				powerups[random[5:4]] <= 1'b1;
				pu_cnt <= PU_W'(game_pkg::POWERUP_FRAMES);
			end

			// extra life is taken once, then the slot frees up
			if (powerups[game_pkg::PU_LIFE]) begin
				if (num_of_hearts < 2'(game_pkg::MAX_HEARTS))
					num_of_hearts <= num_of_hearts + 2'd1;
				powerups[game_pkg::PU_LIFE] <= 1'b0;
			end
		end
	end

	assign player_red = (red_cnt != '0);
	assign shield = powerups[game_pkg::PU_SHIELD];
	assign rapid = powerups[game_pkg::PU_RAPID]; // shorter shot cooldown
	assign more_damage = powerups[game_pkg::PU_DAMAGE];

endmodule

/* rtl/game_top.sv */
`timescale 1ns/1ps

module game_top #(
	parameter int MAX_SHOTS = 8,
	parameter int MAX_TREES = 16
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input logic shoot,
	input logic [3:0] bird_alive,
	input logic hit_pulse,
	input logic god_mode,
	input logic pickup_hit,
	input logic out_of_time,
	input logic [7:0] random,
	output logic [2:0] tree_speed,
	output logic [1:0] bird_speed,
	output game_pkg::bcd2_t level_num,
	output logic [MAX_SHOTS-1:0] deploy_shot,
	output logic [MAX_TREES-1:0] deploy_tree,
	output logic [3:0] deploy_bird,
	output logic deploy_pickup,
	output logic add_time,
	output game_pkg::bcd2_t time_to_add,
	output logic player_active,
	output logic player_red,
	output logic shield,
	output logic more_damage,
	output logic [1:0] num_of_hearts
);

	logic rapid;

	level_if i_level_if ();

	level_fsm i_level_fsm (
		.clk(clk),
		.resetN(resetN),
		.lvl(i_level_if.fsm_side),
		.tree_speed(tree_speed),
		.bird_speed(bird_speed),
		.level_num(level_num)
	);

	game_controller #(
		.MAX_SHOTS(MAX_SHOTS),
		.MAX_TREES(MAX_TREES)
	) i_game_controller (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.shoot(shoot),
		.bird_alive(bird_alive),
		.player_active(player_active),
		.rapid(rapid),
		.lvl(i_level_if.ctrl_side),
		.deploy_shot(deploy_shot),
		.deploy_tree(deploy_tree),
		.deploy_bird(deploy_bird),
		.deploy_pickup(deploy_pickup),
		.add_time(add_time),
		.time_to_add(time_to_add)
	);

	player_status i_player_status (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.hit_pulse(hit_pulse),
		.god_mode(god_mode),
		.pickup_hit(pickup_hit),
		.out_of_time(out_of_time),
		.random(random),
		.player_active(player_active),
		.player_red(player_red),
		.shield(shield),
		.more_damage(more_damage),
		.rapid(rapid),
		.num_of_hearts(num_of_hearts)
	);

endmodule

/* verification/tb_game_top.sv */
`timescale 1ns/1ps

module tb_game_top;

	localparam int FIELDS = 21; // hex words per case line
	localparam int MAX_ROWS = 32;

	logic clk = 1'b0;
	logic resetN = 1'b0;
	logic start_of_frame = 1'b0;
	logic shoot = 1'b0;
	logic [3:0] bird_alive = 4'd0;
	logic hit_pulse = 1'b0;
	logic god_mode = 1'b0;
	logic pickup_hit = 1'b0;
	logic out_of_time = 1'b0;
	logic [7:0] random = 8'd0;
	logic [2:0] tree_speed;
	logic [1:0] bird_speed;
	game_pkg::bcd2_t level_num;
	logic [7:0] deploy_shot;
	logic [15:0] deploy_tree;
	logic [3:0] deploy_bird;
	logic deploy_pickup;
	logic add_time;
	game_pkg::bcd2_t time_to_add;
	logic player_active;
	logic player_red;
	logic shield;
	logic more_damage;
	logic [1:0] num_of_hearts;

	logic [15:0] cases [FIELDS*MAX_ROWS];
	string field_names [11] = '{"num_of_hearts", "player_red", "shield", "more_damage",
		"player_active", "level_num", "deploy_shot count", "deploy_shot slots",
		"add_time count", "deploy_bird slots", "deploy_pickup count"};
	int cycle_cnt = 0;
	int cycle_limit;
	int err_cnt; // errors in the running test
	int pass_cnt = 0;
	int fail_cnt = 0;
	int shot_cnt;
	int add_cnt;
	int pickup_cnt;
	logic [7:0] shot_or;
	logic [3:0] bird_or;
	logic [15:0] tree_exp; // expected deploy_tree this frame
	int frame_no = 0; // frames since reset
	int trees_left = 0;
	int tree_slot = 0;
	int pause_left = 0;
	int level_exp = 0; // table index of the running level
	logic birds_up = 1'b0;

	game_top #(.MAX_SHOTS(8), .MAX_TREES(16)) i_game_top (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout, run still busy after %0d cycles", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (expected == actual) else begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic apply_reset();
		resetN = 1'b0;
		frame_no = 0;
		trees_left = 0;
		tree_slot = 0;
		pause_left = 0;
		level_exp = 0;
		birds_up = 1'b0;
		repeat (4) @(posedge clk);
		#2 resetN = 1'b1;
		check_value("add_time", 16'h1, 16'(add_time)); // initial time load
		check_value("time_to_add", 16'h99, 16'(time_to_add));
		@(posedge clk);
		#2;
	endtask

	task automatic drive_inputs(input int base);
		shoot = cases[base + 2][0];
		bird_alive = cases[base + 3][3:0];
		hit_pulse = cases[base + 4][0];
		god_mode = cases[base + 5][0];
		pickup_hit = cases[base + 6][0];
		random = cases[base + 7][7:0];
		out_of_time = cases[base + 8][0];
	endtask

	// one tree per period while stock lasts
	task automatic predict_trees();
		frame_no++;
		tree_exp = '0;
		if (frame_no % game_pkg::TREE_PERIOD == 0 && trees_left > 0) begin
			tree_exp[tree_slot] = 1'b1;
			tree_slot = (tree_slot + 1) % $bits(deploy_tree);
			trees_left--;
		end
		if (frame_no == 1 || pause_left == 1)
			trees_left += int'(game_pkg::LEVEL_TABLE[level_exp].trees_to_add); // level start
		if (pause_left > 0)
			pause_left--;
		if (bird_alive != 4'd0) begin
			birds_up = 1'b1;
		end else if (birds_up) begin
			birds_up = 1'b0; // level cleared
			pause_left = game_pkg::LEVEL_PAUSE_FRAMES;
			if (level_exp < game_pkg::NUM_LEVELS - 1)
				level_exp++;
		end
	endtask

	task automatic run_frame();
		int gap;
		predict_trees();
		start_of_frame = 1'b1;
		@(posedge clk);
		#2 start_of_frame = 1'b0;
		shot_cnt += $countones(deploy_shot); // pulses live one frame
		shot_or |= deploy_shot;
		add_cnt += int'(add_time);
		bird_or |= deploy_bird;
		pickup_cnt += int'(deploy_pickup);
		check_value("deploy_tree", tree_exp, deploy_tree);
		if (add_time)
			check_value("time_to_add", 16'h10, 16'(time_to_add)); // kill bonus
		gap = $urandom_range(4, 1);
		repeat (gap) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic check_results(input int base);
		logic [15:0] mask;
		logic [15:0] actual [11];
		int idx;
		logic [1:0] lvl_idx;
		mask = cases[base + 20];
		actual[0] = 16'(num_of_hearts);
		actual[1] = 16'(player_red);
		actual[2] = 16'(shield);
		actual[3] = 16'(more_damage);
		actual[4] = 16'(player_active);
		actual[5] = 16'(level_num);
		actual[6] = 16'(shot_cnt);
		actual[7] = 16'(shot_or);
		actual[8] = 16'(add_cnt);
		actual[9] = 16'(bird_or);
		actual[10] = 16'(pickup_cnt);
		for (int i = 0; i < 11; i++) begin
			if (mask[i])
				check_value(field_names[i], cases[base + 9 + i], actual[i]);
		end
		idx = int'(cases[base + 14][7:4]) * 10 + int'(cases[base + 14][3:0]) - 1;
		lvl_idx = (idx > game_pkg::NUM_LEVELS - 1) ? 2'(game_pkg::NUM_LEVELS - 1) : 2'(idx);
		if (mask[5]) begin
			check_value("tree_speed", 16'(game_pkg::LEVEL_TABLE[lvl_idx].tree_speed),
				16'(tree_speed));
			check_value("bird_speed", 16'(game_pkg::LEVEL_TABLE[lvl_idx].bird_speed),
				16'(bird_speed));
		end
	endtask

	initial begin
		int row;
		int base;
		int total_frames;
		void'($urandom(32'hd917_c7bd));
		foreach (cases[i])
			cases[i] = '0;
		$readmemh("verification/game_cases.txt", cases);
		total_frames = 0;
		for (row = 0; row < MAX_ROWS; row++)
			total_frames += int'(cases[row * FIELDS + 1]);
		cycle_limit = total_frames * 6 + 200;
		row = 0;
		while (row < MAX_ROWS && cases[row * FIELDS] != 16'h0) begin
			base = row * FIELDS;
			err_cnt = 0;
			shot_cnt = 0;
			add_cnt = 0;
			pickup_cnt = 0;
			shot_or = 8'd0;
			bird_or = 4'd0;
			drive_inputs(base);
			if (cases[base + 1] == 16'h0)
				apply_reset(); // zero frames means a reset step
			else
				repeat (int'(cases[base + 1])) run_frame();
			check_results(base);
			if (err_cnt == 0) begin
				pass_cnt++;
				$display("test %02h: pass", cases[base][7:0]);
			end else begin
				fail_cnt++;
				$display("test %02h: FAIL, %0d errors", cases[base][7:0], err_cnt);
			end
			row++;
		end
		$display("tests run %0d, good %0d, bad %0d", row, pass_cnt, fail_cnt);
		if (fail_cnt == 0 && pass_cnt > 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* verification/game_cases.txt */
// id frames shoot birds hit god pickup random oot, then expected hearts red shield damage
// active level shots shot_slots add_time bird_slots pickups, then check mask (all hex)
01 000 0 0 0 0 0 00 0  3 0 0 0 1 01  0 00 0 0 0  7FF
02 001 0 0 0 0 0 00 0  3 0 0 0 1 01  0 00 0 1 1  7FF
03 078 1 0 0 0 0 00 0  3 0 0 0 1 01  3 07 0 0 0  7FF
04 001 0 0 0 0 1 10 0  3 0 0 0 1 01  0 00 0 0 0  7FF
05 046 1 0 0 0 0 00 0  3 0 0 0 1 01  3 38 0 0 0  7FF
06 001 0 0 1 0 0 00 0  2 1 0 0 1 01  0 00 0 0 0  7FF
07 001 0 0 1 0 0 00 0  2 1 0 0 1 01  0 00 0 0 0  7FF
08 046 0 0 0 0 0 00 0  2 0 0 0 1 01  0 00 0 0 0  7FF
09 001 0 0 1 1 0 00 0  2 0 0 0 1 01  0 00 0 0 0  7FF
0A 001 0 0 0 0 1 30 0  2 0 0 0 1 01  0 00 0 0 0  7FF
0B 001 0 0 0 0 0 00 0  3 0 0 0 1 01  0 00 0 0 0  7FF
0C 001 0 0 0 0 1 20 0  3 0 0 1 1 01  0 00 0 0 0  7FF
0D 001 0 0 0 0 1 00 0  3 0 1 1 1 01  0 00 0 0 0  7FF
0E 001 0 0 1 0 0 00 0  3 0 1 1 1 01  0 00 0 0 0  7FF
0F 3DE 0 0 0 0 0 00 0  3 0 1 1 1 01  0 00 0 0 0  7FF
10 00F 0 0 0 0 0 00 0  3 0 0 0 1 01  0 00 0 0 0  7FF
11 001 0 1 0 0 0 00 0  3 0 0 0 1 01  0 00 0 0 0  7FF
12 001 0 0 0 0 0 00 0  3 0 0 0 1 02  0 00 1 0 0  7FF
13 063 0 0 0 0 0 00 0  3 0 0 0 1 02  0 00 0 0 0  7FF
14 001 0 0 0 0 0 00 0  3 0 0 0 1 02  0 00 0 3 1  7FF
15 083 0 0 1 0 0 00 0  0 0 0 0 0 02  0 00 0 0 0  7FF
16 000 0 0 0 0 0 00 0  3 0 0 0 1 01  0 00 0 0 0  7FF
17 001 0 0 0 0 0 00 1  3 0 0 0 0 01  0 00 0 1 1  7FF

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_game_top -f flist.f -Mdir obj_dir -o sim_game

out=$(./obj_dir/sim_game)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi

/* flist.f */
rtl/game_pkg.sv
rtl/level_if.sv
rtl/level_fsm.sv
rtl/game_controller.sv
rtl/player_status.sv
rtl/game_top.sv
verification/tb_game_top.sv
